// ==== hdl/dmem_pkg.sv ====
package dmem_pkg;

    // RISC-V load/store funct3 encodings
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_mode_e;

    localparam int WORD_BYTES  = 4;
    localparam int BLOCK_WORDS = 2;
    localparam int BLOCK_BYTES = BLOCK_WORDS * WORD_BYTES;
    localparam int OFFSET_W    = $clog2(BLOCK_BYTES);  // Byte offset bits within a block

    // One little-endian cache block
    // Word view for fills and reads, byte view for store merges
    typedef union packed {
        logic [BLOCK_WORDS-1:0][31:0] words;
        logic [BLOCK_BYTES-1:0][7:0]  bytes;
    } cache_block_u;

endpackage

// ==== hdl/lsu_decode.sv ====
module lsu_decode #(
    parameter int ADDR_WIDTH = 12,
    parameter int SETS = 64,
    localparam int INDEX_W = $clog2(SETS),
    localparam int TAG_W = ADDR_WIDTH - INDEX_W - dmem_pkg::OFFSET_W
) (
    input  dmem_pkg::mem_mode_e                req_mode,
    input  logic [ADDR_WIDTH-1:0]              req_addr,
    input  logic [31:0]                        req_wdata,
    output logic [INDEX_W-1:0]                 dec_index,
    output logic [TAG_W-1:0]                   dec_tag,
    output logic                               dec_word_sel,
    output logic [dmem_pkg::BLOCK_BYTES-1:0]   dec_byte_en,
    output dmem_pkg::cache_block_u             dec_wdata
);
    import dmem_pkg::*;

    logic [OFFSET_W-1:0]    byte_off;
    logic [BLOCK_BYTES-1:0] base_mask;

    assign byte_off     = req_addr[OFFSET_W-1:0];
    assign dec_index    = req_addr[OFFSET_W +: INDEX_W];
    assign dec_tag      = req_addr[ADDR_WIDTH-1 -: TAG_W];
    assign dec_word_sel = req_addr[OFFSET_W-1];  // Upper or lower word of the block

    always_comb begin
        case (req_mode)
            MEM_BYTE, MEM_BYTE_U: base_mask = BLOCK_BYTES'(1);
            MEM_HALF, MEM_HALF_U: base_mask = BLOCK_BYTES'(3);
            MEM_WORD:             base_mask = BLOCK_BYTES'(15);
            default:              base_mask = '0;  // Reserved encodings write nothing
        endcase
    end

    // Accesses are aligned so a plain shift never wraps
    assign dec_byte_en = base_mask << byte_off;

    // Repeat the store data across the block so every lane holds the right byte
    always_comb begin
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            case (req_mode)
                MEM_BYTE, MEM_BYTE_U: begin
                    dec_wdata.bytes[i] = req_wdata[7:0];
                end
                MEM_HALF, MEM_HALF_U: begin
                    dec_wdata.bytes[i] = req_wdata[8*(i%2) +: 8];
                end
                default: begin
                    dec_wdata.bytes[i] = req_wdata[8*(i%WORD_BYTES) +: 8];
                end
            endcase
        end
    end

endmodule

// ==== hdl/write_through_cache.sv ====
module write_through_cache #(
    parameter int ADDR_WIDTH = 12,
    parameter int SETS = 64,
    parameter int RAM_LATENCY = 3,
    localparam int INDEX_W = $clog2(SETS),
    localparam int TAG_W = ADDR_WIDTH - INDEX_W - dmem_pkg::OFFSET_W
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_valid,
    input  logic                                 req_we,
    input  dmem_pkg::mem_mode_e                  req_mode,
    input  logic [ADDR_WIDTH-1:0]                req_addr,
    input  logic [INDEX_W-1:0]                   dec_index,
    input  logic [TAG_W-1:0]                     dec_tag,
    input  logic                                 dec_word_sel,
    input  logic [dmem_pkg::BLOCK_BYTES-1:0]     dec_byte_en,
    input  dmem_pkg::cache_block_u               dec_wdata,
    input  logic                                 ram_rd_done,
    input  logic [8*dmem_pkg::BLOCK_BYTES-1:0]   ram_rd_block,
    output logic                                 req_ready,
    output logic                                 ram_rd_valid,
    output logic [ADDR_WIDTH-1:0]                ram_rd_addr,
    output logic                                 ram_wr_en,
    output logic [ADDR_WIDTH-1:0]                ram_wr_addr,
    output logic [dmem_pkg::WORD_BYTES-1:0]      ram_wr_be,
    output logic [31:0]                          ram_wr_data,
    output logic                                 hit_valid,
    output logic [31:0]                          hit_word,
    output logic [1:0]                           hit_offset,
    output dmem_pkg::mem_mode_e                  hit_mode
);
    import dmem_pkg::*;

    localparam int CNT_W = $clog2(RAM_LATENCY + 1);
    localparam logic IDLE = 1'b0;
    localparam logic FILL = 1'b1;

    cache_block_u       blocks [SETS];
    logic [TAG_W-1:0]   tags [SETS];
    logic [SETS-1:0]    valid;

    logic               state;
    logic [CNT_W-1:0]   fill_cnt;

    // Request held for the duration of a fill
    logic [INDEX_W-1:0]     r_index;
    logic [TAG_W-1:0]       r_tag;
    logic                   r_word_sel;
    logic [BLOCK_BYTES-1:0] r_byte_en;
    cache_block_u           r_wdata;
    logic                   r_we;
    mem_mode_e              r_mode;
    logic [1:0]             r_offset;

    logic                   accept;
    logic                   hit;
    logic                   store_hit;
    logic                   fill_done;
    cache_block_u           src_block;
    cache_block_u           src_data;
    cache_block_u           merged;
    logic [BLOCK_BYTES-1:0] src_be;
    logic                   src_word_sel;
    logic [INDEX_W-1:0]     blk_index;

    assign accept    = req_valid && req_ready;
    assign hit       = valid[dec_index] && (tags[dec_index] == dec_tag);
    assign store_hit = accept && req_we && hit;
    // Only the response belonging to this fill's slot counts
    assign fill_done = (state == FILL) && (fill_cnt == '0) && ram_rd_done;

    assign ram_rd_addr = {r_tag, r_index, {OFFSET_W{1'b0}}};

    // One merge path serves store hits and the block arriving from RAM
    always_comb begin
        if (fill_done) begin
            src_block    = ram_rd_block;
            src_data     = r_wdata;
            src_be       = r_we ? r_byte_en : '0;
            src_word_sel = r_word_sel;
            blk_index    = r_index;
        end else begin
            src_block    = blocks[dec_index];
            src_data     = dec_wdata;
            src_be       = req_we ? dec_byte_en : '0;
            src_word_sel = dec_word_sel;
            blk_index    = dec_index;
        end
        merged = src_block;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            if (src_be[i]) merged.bytes[i] = src_data.bytes[i];
        end
    end

    // The RAM sees every store on the same edge as the cache
    assign ram_wr_en   = store_hit || (fill_done && r_we);
    assign ram_wr_addr = fill_done ? {r_tag, r_index, r_word_sel, 2'b00}
                                   : {req_addr[ADDR_WIDTH-1:2], 2'b00};
    assign ram_wr_be   = src_be[src_word_sel*WORD_BYTES +: WORD_BYTES];
    assign ram_wr_data = merged.words[src_word_sel];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= IDLE;
            req_ready    <= 1'b0;
            ram_rd_valid <= 1'b0;
            hit_valid    <= 1'b0;
            fill_cnt     <= '0;
            valid        <= '0;
        end else begin
            ram_rd_valid <= 1'b0;
            hit_valid    <= 1'b0;
            case (state)
                IDLE: begin
                    req_ready <= 1'b1;
                    if (accept && hit) begin
                        hit_valid <= !req_we;
                    end else if (accept) begin  // Miss so fetch the block from RAM
                        state        <= FILL;
                        req_ready    <= 1'b0;
                        ram_rd_valid <= 1'b1;
                        fill_cnt     <= CNT_W'(RAM_LATENCY);
                    end
                end
                FILL: begin
                    if (fill_cnt != '0) fill_cnt <= fill_cnt - 1'b1;
                    if (fill_done) begin
                        valid[r_index] <= 1'b1;
                        hit_valid      <= !r_we;
                        req_ready      <= 1'b1;
                        state          <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit || fill_done) blocks[blk_index] <= merged;
        if (fill_done) tags[r_index] <= r_tag;
        if (accept) begin
            r_index    <= dec_index;
            r_tag      <= dec_tag;
            r_word_sel <= dec_word_sel;
            r_byte_en  <= dec_byte_en;
            r_wdata    <= dec_wdata;
            r_we       <= req_we;
            r_mode     <= req_mode;
            r_offset   <= req_addr[1:0];
        end
        if (accept || fill_done) begin
            hit_word   <= merged.words[src_word_sel];
            hit_offset <= fill_done ? r_offset : req_addr[1:0];
            hit_mode   <= fill_done ? r_mode : req_mode;
        end
    end

endmodule

// ==== hdl/backing_ram.sv ====
module backing_ram #(
    parameter int ADDR_WIDTH = 12,
    parameter int RAM_LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   rd_valid,
    input  logic [ADDR_WIDTH-1:0]  rd_addr,
    input  logic                   wr_en,
    input  logic [ADDR_WIDTH-1:0]  wr_addr,
    input  logic [3:0]             wr_be,
    input  logic [31:0]            wr_data,
    output logic                   rd_done,
    output logic [63:0]            rd_block
);

    localparam int WORDS = 2**(ADDR_WIDTH-2);

    logic [31:0]             mem [WORDS];
    logic [ADDR_WIDTH-4:0]   rd_blk;
    logic [ADDR_WIDTH-3:0]   wr_word;

    // Fixed-latency read pipeline with one slot per cycle
    logic [RAM_LATENCY-1:0]  pipe_valid;
    logic [63:0]             pipe_block [RAM_LATENCY];

    assign rd_blk  = rd_addr[ADDR_WIDTH-1:3];
    assign wr_word = wr_addr[ADDR_WIDTH-1:2];

    always_ff @(posedge clk) begin
        pipe_valid[0] <= rd_valid;
        pipe_block[0] <= {mem[{rd_blk, 1'b1}], mem[{rd_blk, 1'b0}]};  // Little-endian
        for (int i = 1; i < RAM_LATENCY; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
            pipe_block[i] <= pipe_block[i-1];
        end
    end

    assign rd_done  = pipe_valid[RAM_LATENCY-1];
    assign rd_block = pipe_block[RAM_LATENCY-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) mem[wr_word][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

endmodule

// ==== hdl/load_result.sv ====
module load_result (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hit_valid,
    input  logic [31:0]          hit_word,
    input  logic [1:0]           hit_offset,
    input  dmem_pkg::mem_mode_e  hit_mode,
    output logic                 rsp_valid,
    output logic [31:0]          rsp_data
);
    import dmem_pkg::*;

    logic [31:0]  r_word;
    logic [1:0]   r_offset;
    mem_mode_e    r_mode;
    logic [7:0]   sel_byte;
    logic [15:0]  sel_half;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= hit_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid) begin
            r_word   <= hit_word;
            r_offset <= hit_offset;
            r_mode   <= hit_mode;
        end
    end

    assign sel_byte = r_word[8*r_offset +: 8];
    assign sel_half = r_word[16*r_offset[1] +: 16];  // Halves are aligned

    always_comb begin
        case (r_mode)
            MEM_BYTE:   rsp_data = {{24{sel_byte[7]}}, sel_byte};
            MEM_BYTE_U: rsp_data = {24'h0, sel_byte};
            MEM_HALF:   rsp_data = {{16{sel_half[15]}}, sel_half};
            MEM_HALF_U: rsp_data = {16'h0, sel_half};
            default:    rsp_data = r_word;
        endcase
    end

endmodule

// ==== hdl/data_mem_top.sv ====
module data_mem_top #(
    parameter int ADDR_WIDTH = 12,
    parameter int SETS = 64,
    parameter int RAM_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 req_we,
    input  dmem_pkg::mem_mode_e  req_mode,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [31:0]          req_wdata,
    output logic                 rsp_valid,
    output logic [31:0]          rsp_data
);
    import dmem_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_WIDTH - INDEX_W - OFFSET_W;

    // Decode to cache
    logic [INDEX_W-1:0]      dec_index;
    logic [TAG_W-1:0]        dec_tag;
    logic                    dec_word_sel;
    logic [BLOCK_BYTES-1:0]  dec_byte_en;
    cache_block_u            dec_wdata;

    // Cache to RAM
    logic                    ram_rd_valid;
    logic [ADDR_WIDTH-1:0]   ram_rd_addr;
    logic                    ram_rd_done;
    logic [63:0]             ram_rd_block;
    logic                    ram_wr_en;
    logic [ADDR_WIDTH-1:0]   ram_wr_addr;
    logic [WORD_BYTES-1:0]   ram_wr_be;
    logic [31:0]             ram_wr_data;

    // Cache to result
    logic                    hit_valid;
    logic [31:0]             hit_word;
    logic [1:0]              hit_offset;
    mem_mode_e               hit_mode;

    lsu_decode #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SETS       (SETS)
    ) u_decode (
        .req_mode     (req_mode),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .dec_index    (dec_index),
        .dec_tag      (dec_tag),
        .dec_word_sel (dec_word_sel),
        .dec_byte_en  (dec_byte_en),
        .dec_wdata    (dec_wdata)
    );

    write_through_cache #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .SETS        (SETS),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_we       (req_we),
        .req_mode     (req_mode),
        .req_addr     (req_addr),
        .dec_index    (dec_index),
        .dec_tag      (dec_tag),
        .dec_word_sel (dec_word_sel),
        .dec_byte_en  (dec_byte_en),
        .dec_wdata    (dec_wdata),
        .ram_rd_done  (ram_rd_done),
        .ram_rd_block (ram_rd_block),
        .req_ready    (req_ready),
        .ram_rd_valid (ram_rd_valid),
        .ram_rd_addr  (ram_rd_addr),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_addr  (ram_wr_addr),
        .ram_wr_be    (ram_wr_be),
        .ram_wr_data  (ram_wr_data),
        .hit_valid    (hit_valid),
        .hit_word     (hit_word),
        .hit_offset   (hit_offset),
        .hit_mode     (hit_mode)
    );

    backing_ram #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_ram (
        .clk      (clk),
        .rd_valid (ram_rd_valid),
        .rd_addr  (ram_rd_addr),
        .wr_en    (ram_wr_en),
        .wr_addr  (ram_wr_addr),
        .wr_be    (ram_wr_be),
        .wr_data  (ram_wr_data),
        .rd_done  (ram_rd_done),
        .rd_block (ram_rd_block)
    );

    load_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .hit_valid  (hit_valid),
        .hit_word   (hit_word),
        .hit_offset (hit_offset),
        .hit_mode   (hit_mode),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

endmodule

// ==== testbench/tb_data_mem.sv ====
module tb_data_mem;
    timeunit 1ns;
    timeprecision 1ps;
    import dmem_pkg::*;

    localparam int ADDR_WIDTH     = 12;
    localparam int RAM_LATENCY    = 3;
    localparam int HIT_LAT        = 1;
    localparam int MISS_LAT       = RAM_LATENCY + 2;
    localparam int RANDOM_OPS     = 300;
    localparam int N_OPS          = 33 + 2 + 64 + 12 + 16 + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = N_OPS * (RAM_LATENCY + 4) + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_we;
    mem_mode_e             req_mode;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [31:0]           req_wdata;
    logic                  rsp_valid;
    logic [31:0]           rsp_data;

    logic [7:0]  mem_model [2**ADDR_WIDTH];  // Byte image of the backing RAM
    logic [31:0] exp_data_q [$];
    string       exp_name_q [$];
    int          exp_accept_q [$];
    int          exp_lat_q [$];  // -1 when latency is not checked

    int cycle_cnt      = 0;
    int data_errors    = 0;
    int latency_errors = 0;
    int ready_errors   = 0;
    int other_errors   = 0;
    int seed           = 32'h4af7_523a;

    data_mem_top u_data_mem_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_we    (req_we),
        .req_mode  (req_mode),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d loads still waiting for a response",
                     cycle_cnt, exp_data_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    // Word value that differs for every address
    function automatic logic [31:0] addr_pattern(input logic [ADDR_WIDTH-1:0] addr);
        return {4'h9, addr, 4'h6, addr ^ 12'h5a3};
    endfunction

    function automatic logic [31:0] model_load(input logic [ADDR_WIDTH-1:0] addr,
                                               input mem_mode_e mode);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = mem_model[int'(addr)];
        h = {mem_model[int'(addr) + 1], b};
        w = {mem_model[int'(addr) + 3], mem_model[int'(addr) + 2], h};
        case (mode)
            MEM_BYTE:   return {{24{b[7]}}, b};
            MEM_BYTE_U: return {24'h0, b};
            MEM_HALF:   return {{16{h[15]}}, h};
            MEM_HALF_U: return {16'h0, h};
            default:    return w;
        endcase
    endfunction

    // Low bytes of wdata go to the lowest address
    function automatic void model_store(input logic [ADDR_WIDTH-1:0] addr,
                                        input mem_mode_e mode, input logic [31:0] wdata);
        int n;
        case (mode)
            MEM_BYTE, MEM_BYTE_U: n = 1;
            MEM_HALF, MEM_HALF_U: n = 2;
            default:              n = 4;
        endcase
        for (int i = 0; i < n; i++) begin
            mem_model[int'(addr) + i] = wdata[8*i +: 8];
        end
    endfunction

    task automatic check_data(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            data_errors++;
            $display("FAIL %s data expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            latency_errors++;
            $display("FAIL %s latency expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            ready_errors++;
            $display("FAIL %s req_ready expected %b actual %b", name, expected, actual);
        end
    endtask

    // Called on a falling edge and returns on the falling edge after the accept
    task automatic issue_request(input logic we, input mem_mode_e mode,
                                 input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] wdata,
                                 input string test, input int lat);
        req_valid = 1'b1;
        req_we    = we;
        req_mode  = mode;
        req_addr  = addr;
        req_wdata = wdata;
        while (!req_ready) @(negedge clk);
        if (we) begin
            model_store(addr, mode, wdata);
        end else begin
            exp_data_q.push_back(model_load(addr, mode));
            exp_name_q.push_back($sformatf("%s @%h mode %s", test, addr, mode.name()));
            exp_accept_q.push_back(cycle_cnt + 1);  // Counter value after the accept edge
            exp_lat_q.push_back(lat);
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (lat == MISS_LAT) begin
            check_ready(test, 1'b0, req_ready);  // A miss stalls the next request
        end else if (lat == HIT_LAT) begin
            check_ready(test, 1'b1, req_ready);
        end
    endtask

    task automatic wait_idle();
        while (!req_ready || exp_data_q.size() != 0) @(negedge clk);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        check_ready("reset", 1'b0, req_ready);
        rst_n = 1'b1;
        @(negedge clk);
        check_ready("reset_release", 1'b1, req_ready);
    endtask

    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            if (exp_data_q.size() == 0) begin
                other_errors++;
                $display("Unexpected response %h arrived with no load outstanding", rsp_data);
            end else begin
                check_data(exp_name_q[0], exp_data_q[0], rsp_data);
                if (exp_lat_q[0] >= 0) begin
                    check_latency(exp_name_q[0], exp_lat_q[0], cycle_cnt - exp_accept_q[0]);
                end
                void'(exp_data_q.pop_front());
                void'(exp_name_q.pop_front());
                void'(exp_accept_q.pop_front());
                void'(exp_lat_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0]           rnd;
        logic [ADDR_WIDTH-1:0] addr;
        mem_mode_e             mode;
        int                    gap;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_mode  = MEM_WORD;
        req_addr  = '0;
        req_wdata = '0;
        apply_reset();

        // One word per block so every reload after the reset misses
        for (int k = 0; k < 16; k++) begin
            addr = ADDR_WIDTH'(8 * k);
            issue_request(1'b1, MEM_WORD, addr, addr_pattern(addr), "write_through", -1);
        end
        issue_request(1'b1, MEM_WORD, 12'h0c4, addr_pattern(12'h0c4), "write_through", -1);
        wait_idle();
        apply_reset();
        for (int k = 0; k < 16; k++) begin
            addr = ADDR_WIDTH'(8 * k);
            issue_request(1'b0, MEM_WORD, addr, '0, "write_through", MISS_LAT);
        end

        issue_request(1'b0, MEM_WORD, 12'h0c4, '0, "latency_miss", MISS_LAT);
        issue_request(1'b0, MEM_WORD, 12'h0c4, '0, "latency_hit", HIT_LAT);

        // Odd offsets get negative bytes and halves
        for (int i = 0; i < 8; i++) begin
            rnd = 32'hdead_be10 + 32'(i) + ((i % 2 == 1) ? 32'h80 : 32'h0);
            issue_request(1'b1, MEM_BYTE, ADDR_WIDTH'(12'h100 + i), rnd, "widths", -1);
            check_ready("widths_store", (i != 0), req_ready);  // Only the first store misses
        end
        for (int j = 0; j < 4; j++) begin
            rnd = 32'h5555_1b00 + 32'(j) + ((j % 2 == 1) ? 32'h8000 : 32'h0);
            issue_request(1'b1, MEM_HALF, ADDR_WIDTH'(12'h108 + 2 * j), rnd, "widths", -1);
        end
        for (int off = 0; off < 16; off++) begin
            addr = ADDR_WIDTH'(12'h100 + off);
            issue_request(1'b0, MEM_BYTE, addr, '0, "widths", -1);
            issue_request(1'b0, MEM_BYTE_U, addr, '0, "widths", -1);
            if (off % 2 == 0) begin
                issue_request(1'b0, MEM_HALF, addr, '0, "widths", -1);
                issue_request(1'b0, MEM_HALF_U, addr, '0, "widths", -1);
            end
            if (off % 4 == 0) issue_request(1'b0, MEM_WORD, addr, '0, "widths", -1);
        end

        // 0x200 and 0x400 share set 0
        issue_request(1'b1, MEM_WORD, 12'h200, $random(seed), "conflict", -1);
        issue_request(1'b1, MEM_WORD, 12'h400, $random(seed), "conflict", -1);
        issue_request(1'b0, MEM_WORD, 12'h200, '0, "conflict", -1);
        issue_request(1'b1, MEM_BYTE, 12'h401, $random(seed), "conflict", -1);
        issue_request(1'b0, MEM_WORD, 12'h400, '0, "conflict", -1);
        issue_request(1'b1, MEM_HALF, 12'h202, $random(seed), "conflict", -1);
        issue_request(1'b0, MEM_WORD, 12'h200, '0, "conflict", -1);
        issue_request(1'b0, MEM_BYTE_U, 12'h401, '0, "conflict", -1);
        issue_request(1'b1, MEM_WORD, 12'h204, $random(seed), "conflict", -1);
        issue_request(1'b0, MEM_WORD, 12'h204, '0, "conflict", -1);
        issue_request(1'b0, MEM_HALF, 12'h402, '0, "conflict", -1);
        issue_request(1'b0, MEM_WORD, 12'h200, '0, "conflict", -1);

        // Random window is two aliasing 32-byte regions that are filled first
        for (int k = 0; k < 8; k++) begin
            addr = ADDR_WIDTH'(12'h300 + 4 * k);
            issue_request(1'b1, MEM_WORD, addr, addr_pattern(addr), "random_fill", -1);
            addr = ADDR_WIDTH'(12'h500 + 4 * k);
            issue_request(1'b1, MEM_WORD, addr, addr_pattern(addr), "random_fill", -1);
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd = $random(seed);
            case (rnd[7:0] % 8'd5)
                8'd0:    mode = MEM_BYTE;
                8'd1:    mode = MEM_HALF;
                8'd2:    mode = MEM_WORD;
                8'd3:    mode = MEM_BYTE_U;
                default: mode = MEM_HALF_U;
            endcase
            addr = (rnd[8] ? 12'h500 : 12'h300) + ADDR_WIDTH'(rnd[13:9]);
            if (mode == MEM_WORD) addr[1:0] = 2'b00;
            if (mode == MEM_HALF || mode == MEM_HALF_U) addr[0] = 1'b0;
            gap = (rnd[17:16] == 2'd3) ? 2 : ((rnd[17:16] == 2'd2) ? 1 : 0);
            issue_request(rnd[14], mode, addr, $random(seed), "random", -1);
            repeat (gap) @(negedge clk);
        end

        wait_idle();
        repeat (4) @(negedge clk);  // Catch any stray response
        $display("Errors: data %0d, latency %0d, ready %0d, other %0d",
                 data_errors, latency_errors, ready_errors, other_errors);
        if (data_errors + latency_errors + ready_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/dmem_pkg.sv
hdl/lsu_decode.sv
hdl/write_through_cache.sv
hdl/backing_ram.sv
hdl/load_result.sv
hdl/data_mem_top.sv
testbench/tb_data_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_data_mem -o sim_tb_data_mem
./obj_dir/sim_tb_data_mem | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
